/* compile.f */
+incdir+verification
design/cdc_app_pkg.sv
design/app_ctrl_if.sv
design/app_sequencer.sv
design/app_pacer.sv
design/app_datapath.sv
design/loop_ram.sv
design/cdc_app_top.sv
verification/cdc_app_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it, and looks for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module cdc_app_tb \
   -f compile.f -o cdc_app_sim > build.log 2>&1 \
   && ./obj_dir/cdc_app_sim > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -qx "=== PASS ===" sim.log && exit 0 || exit 1

/* verification/cdc_app_ref.svh */
// reference CRC32 and LFSR models plus the stimulus table, included inside the testbench module
// columns: kind, count N, LFSR seed, min gap, send length, send bytes, expected length, expected
// byte strings read left to right, the leftmost byte is sent or expected first
`ifndef CDC_APP_REF_SVH
`define CDC_APP_REF_SVH

localparam logic [1:0] K_FIXED = 2'd0;
localparam logic [1:0] K_LFSR  = 2'd1;
localparam logic [1:0] K_IN    = 2'd2;
localparam logic [1:0] K_OUT   = 2'd3;
localparam int         NUM_ROWS = 9;

typedef struct packed {
   logic [1:0]   kind;
   logic [23:0]  count;
   logic [23:0]  seed;
   logic [7:0]   gap;
   logic [4:0]   send_len;
   logic [127:0] send;
   logic [4:0]   exp_len;
   logic [127:0] exp;
} row_t;

localparam row_t STIM [NUM_ROWS] = '{
   '{K_FIXED, 24'd0, 24'h0, 8'd0, 5'd6, 128'h3c_a5_17_e2_5b_90, 5'd6, 128'h3c_a5_17_e2_5b_90},
   '{K_FIXED, 24'd0, 24'h0, 8'd0, 5'd5, 128'h00_03_00_00_00, 5'd0, 128'h0},
   '{K_FIXED, 24'd0, 24'h0, 8'd0, 5'd5, 128'h00_08_04_00_00, 5'd5, 128'h3c_a5_17_e2_5b},
   '{K_LFSR, 24'd0, 24'h0, 8'd0, 5'd0, 128'h0, 5'd0, 128'h0},
   '{K_IN, 24'd7, 24'h5a_c31e, 8'd0, 5'd0, 128'h0, 5'd0, 128'h0},
   '{K_OUT, 24'd5, 24'h0, 8'd0, 5'd0, 128'h0, 5'd0, 128'h0},
   '{K_FIXED, 24'd0, 24'h0, 8'd0, 5'd3, 128'h00_04_03, 5'd0, 128'h0},
   '{K_IN, 24'd7, 24'h5a_c31e, 8'd3, 5'd0, 128'h0, 5'd0, 128'h0},
   '{K_FIXED, 24'd0, 24'h0, 8'd0, 5'd2, 128'h71_08, 5'd2, 128'h71_08}
};

function automatic logic [7:0] row_byte(input logic [127:0] v, input int len, input int i);
   return v[(len-1-i)*8 +: 8];
endfunction

// taps 23, 22, 21 and 16, XNOR feedback into bit 0
function automatic logic [23:0] ref_lfsr_next(input logic [23:0] s);
   logic fb;
   fb = ~(s[23] ^ s[22] ^ s[21] ^ s[16]);
   return {s[22:0], fb};
endfunction

// reflected CRC32, the byte leaves low byte first after the final inversion
function automatic logic [31:0] ref_crc_byte(input logic [31:0] crc, input logic [7:0] b);
   logic [31:0] c;
   c = crc ^ {24'h0, b};
   for (int i = 0; i < 8; i++) begin
      c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
   end
   return c;
endfunction

`endif

/* verification/cdc_app_tb.sv */
`timescale 1ns/1ps
// testbench for cdc_app_top, rows of the stimulus table run one after the other
// in_ready_i is random, outputs are sampled on the falling edge
module cdc_app_tb;

   localparam int TIMEOUT = 500;
   localparam int DRAIN   = 60;

   logic       clk_i;
   logic       rstn;
   logic [7:0] out_data_i;
   logic       out_valid_i;
   logic       out_ready_o;
   logic [7:0] in_data_o;
   logic       in_valid_o;
   logic       in_ready_i;

   int         errors;
   int         checks;
   int         cyc = 0;
   bit         timed_out;
   logic [7:0] send_q[$];
   logic [7:0] exp_q[$];
   logic [7:0] rcv_q[$];
   logic [7:0] first_in_q[$];

   `include "cdc_app_ref.svh"

   cdc_app_top #(
      .RAM_DEPTH (1024)
   ) DUT (
      .clk_i       (clk_i),
      .rstn        (rstn),
      .out_data_i  (out_data_i),
      .out_valid_i (out_valid_i),
      .out_ready_o (out_ready_o),
      .in_data_o   (in_data_o),
      .in_valid_o  (in_valid_o),
      .in_ready_i  (in_ready_i)
   );

   always #10 clk_i = ~clk_i;

   always @(posedge clk_i) cyc <= cyc + 1;

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic push_crc(input logic [31:0] crc);
      logic [31:0] fin;
      fin = ~crc;
      exp_q.push_back(fin[7:0]);
      exp_q.push_back(fin[15:8]);
      exp_q.push_back(fin[23:16]);
      exp_q.push_back(fin[31:24]);
   endtask

   task automatic build_row(input int r);
      logic [23:0] lfsr;
      logic [23:0] cnt;
      logic [31:0] crc;
      logic [31:0] rnd;
      send_q.delete();
      exp_q.delete();
      crc = 32'hFFFF_FFFF;
      cnt = STIM[r].count;
      case (STIM[r].kind)
         K_FIXED: begin
            for (int i = 0; i < STIM[r].send_len; i++)
               send_q.push_back(row_byte(STIM[r].send, STIM[r].send_len, i));
            for (int i = 0; i < STIM[r].exp_len; i++)
               exp_q.push_back(row_byte(STIM[r].exp, STIM[r].exp_len, i));
         end
         K_LFSR: begin
            rnd    = $urandom;
            send_q = '{8'h00, 8'h05, rnd[7:0], rnd[15:8], rnd[23:16], 8'h00, 8'h06};
            exp_q  = '{rnd[7:0], rnd[15:8], rnd[23:16], 8'h00};
         end
         K_IN: begin
            // reload the LFSR first so repeated rows start from the same state
            lfsr   = STIM[r].seed;
            send_q = '{8'h00, 8'h05, lfsr[7:0], lfsr[15:8], lfsr[23:16],
                       8'h00, 8'h01, cnt[7:0], cnt[15:8], cnt[23:16]};
            for (int i = 0; i <= int'(cnt); i++) begin
               exp_q.push_back(lfsr[7:0]);
               crc  = ref_crc_byte(crc, lfsr[7:0]);
               lfsr = ref_lfsr_next(lfsr);
            end
            push_crc(crc);
         end
         default: begin
            send_q = '{8'h00, 8'h02, cnt[7:0], cnt[15:8], cnt[23:16]};
            for (int i = 0; i <= int'(cnt); i++) begin
               rnd = $urandom;
               send_q.push_back(rnd[7:0]);
               crc = ref_crc_byte(crc, rnd[7:0]);
            end
            push_crc(crc);
         end
      endcase
   endtask

   task automatic run_row(input int r);
      int         sent;
      int         idle;
      int         last_cyc;
      bit         rx_fire;
      bit         tx_fire;
      bit         stalled;
      logic [7:0] stall_data;
      sent       = 0;
      idle       = 0;
      last_cyc   = 0;
      stalled    = 1'b0;
      stall_data = 8'h00;
      rcv_q.delete();
      while ((sent < send_q.size() || rcv_q.size() < exp_q.size()) && !timed_out) begin
         @(negedge clk_i);
         rx_fire = out_valid_i && out_ready_o;
         tx_fire = in_valid_o && in_ready_i;
         // a stalled offer stays on the bus unchanged
         if (stalled) begin
            compare_value($sformatf("in_valid_o held (row %0d)", r), in_valid_o, 1'b1);
            compare_value($sformatf("in_data_o held (row %0d)", r), in_data_o, stall_data);
         end
         stalled    = in_valid_o && !in_ready_i;
         stall_data = in_data_o;
         if (tx_fire) begin
            if (rcv_q.size() < exp_q.size()) begin
               compare_value($sformatf("in_data_o (row %0d byte %0d)", r, rcv_q.size()),
                             in_data_o, exp_q[rcv_q.size()]);
            end else begin
               errors++;
               $display("row %0d: extra byte 0x%0h on the transmit stream", r, in_data_o);
            end
            // every data byte must be followed by the programmed gap
            if (STIM[r].gap != 0 && rcv_q.size() > 0 && rcv_q.size() <= int'(STIM[r].count) + 1
                && cyc - last_cyc <= int'(STIM[r].gap)) begin
               errors++;
               $display("row %0d: byte %0d came %0d cycles after the previous data byte",
                        r, rcv_q.size(), cyc - last_cyc);
            end
            last_cyc = cyc;
            rcv_q.push_back(in_data_o);
         end
         idle = (rx_fire || tx_fire) ? 0 : idle + 1;
         if (idle > TIMEOUT) begin
            timed_out = 1'b1;
            errors++;
            $display("row %0d: timeout with %0d of %0d bytes sent and %0d of %0d received",
                     r, sent, send_q.size(), rcv_q.size(), exp_q.size());
         end
         @(posedge clk_i);
         if (rx_fire)
            sent++;
         out_valid_i <= (sent < send_q.size());
         out_data_i  <= (sent < send_q.size()) ? send_q[sent] : 8'h00;
         in_ready_i  <= (($urandom % 4) != 0);
      end
   endtask

   task automatic compare_repeat(input int r);
      if (first_in_q.size() == 0) begin
         first_in_q = rcv_q;
      end else begin
         for (int i = 0; i < first_in_q.size(); i++)
            compare_value($sformatf("in_data_o repeat (row %0d byte %0d)", r, i),
                          rcv_q[i], first_in_q[i]);
      end
   endtask

   task automatic drain_check();
      for (int i = 0; i < DRAIN; i++) begin
         @(posedge clk_i);
         in_ready_i <= 1'b1;
         @(negedge clk_i);
         if (in_valid_o) begin
            errors++;
            $display("unexpected byte 0x%0h on the transmit stream after the last row", in_data_o);
         end
      end
   endtask

   initial begin
      void'($urandom(32'h8ac9_f8b5));
      clk_i       = 1'b0;
      rstn        = 1'b0;
      out_data_i  = 8'h00;
      out_valid_i = 1'b0;
      in_ready_i  = 1'b0;
      errors      = 0;
      checks      = 0;
      timed_out   = 1'b0;
      repeat (2) @(posedge clk_i);
      rstn <= 1'b1;
      for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
         build_row(r);
         run_row(r);
         if (STIM[r].kind == K_IN && !timed_out)
            compare_repeat(r);
      end
      if (!timed_out)
         drain_check();
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

/* design/cdc_app_top.sv */
`timescale 1ns/1ps
// byte application behind a USB CDC link, valid/ready on both streams
// reset release is synchronized, the streams stay idle for two clocks after it
module cdc_app_top #(
   parameter int RAM_DEPTH = 1024
) (
   input  logic                           clk_i,
   input  logic                           rstn,
   input  logic [cdc_app_pkg::BYTE_W-1:0] out_data_i,
   input  logic                           out_valid_i,
   output logic                           out_ready_o,
   output logic [cdc_app_pkg::BYTE_W-1:0] in_data_o,
   output logic                           in_valid_o,
   input  logic                           in_ready_i
);

   logic [1:0]                     rstn_sq;
   logic                           rstn_sync;
   logic [cdc_app_pkg::BYTE_W-1:0] rx_byte;
   logic                           rx_valid;
   logic [cdc_app_pkg::BYTE_W-1:0] ram_rdata;
   logic                           cnt_zero;
   logic                           wait_done;

   app_ctrl_if ctrl ();

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn)
         rstn_sq <= '0;
      else
         rstn_sq <= {1'b1, rstn_sq[1]};
   end

   assign rstn_sync = rstn_sq[0];

   app_sequencer u_seq (
      .clk_i       (clk_i),
      .rstn        (rstn_sync),
      .ctrl        (ctrl),
      .rx_byte_i   (rx_byte),
      .rx_valid_i  (rx_valid),
      .tx_ready_i  (in_ready_i),
      .cnt_zero_i  (cnt_zero),
      .wait_done_i (wait_done),
      .tx_valid_o  (in_valid_o)
   );

   app_pacer u_pacer (
      .clk_i       (clk_i),
      .rstn        (rstn_sync),
      .ctrl        (ctrl),
      .rx_byte_i   (rx_byte),
      .cnt_zero_o  (cnt_zero),
      .wait_done_o (wait_done)
   );

   app_datapath u_dp (
      .clk_i       (clk_i),
      .rstn        (rstn_sync),
      .ctrl        (ctrl),
      .out_data_i  (out_data_i),
      .out_valid_i (out_valid_i),
      .out_ready_o (out_ready_o),
      .ram_rdata_i (ram_rdata),
      .rx_byte_o   (rx_byte),
      .rx_valid_o  (rx_valid),
      .tx_data_o   (in_data_o)
   );

   // the echoed byte is what gets captured
   loop_ram #(
      .RAM_DEPTH (RAM_DEPTH)
   ) u_ram (
      .clk_i       (clk_i),
      .rstn        (rstn_sync),
      .ctrl        (ctrl),
      .rx_byte_i   (rx_byte),
      .wdata_i     (in_data_o),
      .rdata_o     (ram_rdata)
   );

endmodule

/* design/loop_ram.sv */
`timescale 1ns/1ps
// loopback capture RAM with its own 24-bit address register
// RAM_DEPTH must be a power of two, the address wraps through its low bits
module loop_ram #(
   parameter int RAM_DEPTH = 1024
) (
   input  logic                           clk_i,
   input  logic                           rstn,
   app_ctrl_if.unit                       ctrl,
   input  logic [cdc_app_pkg::BYTE_W-1:0] rx_byte_i,
   input  logic [cdc_app_pkg::BYTE_W-1:0] wdata_i,
   output logic [cdc_app_pkg::BYTE_W-1:0] rdata_o
);

   localparam int AW = $clog2(RAM_DEPTH);

   logic [cdc_app_pkg::BYTE_W-1:0] mem [RAM_DEPTH];
   logic [cdc_app_pkg::CNT_W-1:0]  addr_q;
   logic [AW-1:0]                  idx;

   assign idx = addr_q[AW-1:0];

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn)
         addr_q <= '0;
      else if (ctrl.addr_clr)
         addr_q <= '0;
      else if (ctrl.addr_load)
         addr_q[ctrl.lane*cdc_app_pkg::BYTE_W +: cdc_app_pkg::BYTE_W] <= rx_byte_i;
      else if (ctrl.ram_we | ctrl.ram_rd)
         addr_q <= addr_q + 1'b1;
   end

   // read data shows up the cycle after ram_rd
   always_ff @(posedge clk_i) begin
      if (ctrl.ram_we)
         mem[idx] <= wdata_i;
      if (ctrl.ram_rd)
         rdata_o <= mem[idx];
   end

endmodule

/* design/app_datapath.sv */
`timescale 1ns/1ps
// one-deep receive holding register, CRC32 and LFSR state, transmit byte mux
// CRC bytes leave most significant first as rev8 of the complemented register
module app_datapath (
   input  logic                           clk_i,
   input  logic                           rstn,
   app_ctrl_if.unit                       ctrl,
   input  logic [cdc_app_pkg::BYTE_W-1:0] out_data_i,
   input  logic                           out_valid_i,
   output logic                           out_ready_o,
   input  logic [cdc_app_pkg::BYTE_W-1:0] ram_rdata_i,
   output logic [cdc_app_pkg::BYTE_W-1:0] rx_byte_o,
   output logic                           rx_valid_o,
   output logic [cdc_app_pkg::BYTE_W-1:0] tx_data_o
);

   logic [cdc_app_pkg::BYTE_W-1:0] rx_byte_q;
   logic                           rx_valid_q;
   logic [31:0]                    crc_q;
   logic [31:0]                    crc_out;
   logic [cdc_app_pkg::CNT_W-1:0]  lfsr_q;
   logic                           rx_hs;

   assign out_ready_o = (~rx_valid_q | ctrl.rx_take) & ctrl.rx_open;
   assign rx_hs       = out_valid_i & out_ready_o;
   assign rx_byte_o   = rx_byte_q;
   assign rx_valid_o  = rx_valid_q;
   assign crc_out     = ~crc_q;

   always_ff @(posedge clk_i) begin
      if (rx_hs)
         rx_byte_q <= out_data_i;
   end

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         rx_valid_q <= 1'b0;
         crc_q      <= cdc_app_pkg::CRC_INIT;
         lfsr_q     <= '0;
      end else begin
         if (rx_hs)
            rx_valid_q <= 1'b1;
         else if (ctrl.rx_take)
            rx_valid_q <= 1'b0;

         if (ctrl.crc_init)
            crc_q <= cdc_app_pkg::CRC_INIT;
         else if (ctrl.crc_rx_step)
            crc_q <= cdc_app_pkg::crc32_byte(rx_byte_q, crc_q);
         else if (ctrl.crc_tx_step)
            crc_q <= cdc_app_pkg::crc32_byte(tx_data_o, crc_q);

         // shift left, XNOR feedback of the tapped bits
         if (ctrl.lfsr_load)
            lfsr_q[ctrl.lane*cdc_app_pkg::BYTE_W +: cdc_app_pkg::BYTE_W] <= rx_byte_q;
         else if (ctrl.lfsr_step)
            lfsr_q <= {lfsr_q[cdc_app_pkg::CNT_W-2:0], ~^(lfsr_q & cdc_app_pkg::LFSR_TAPS)};
      end
   end

   always_comb begin
      case (ctrl.tx_sel)
         cdc_app_pkg::TX_LOOP:  tx_data_o = rx_byte_q;
         cdc_app_pkg::TX_LFSR0: tx_data_o = lfsr_q[7:0];
         cdc_app_pkg::TX_LFSR1: tx_data_o = lfsr_q[15:8];
         cdc_app_pkg::TX_LFSR2: tx_data_o = lfsr_q[23:16];
         cdc_app_pkg::TX_CRC0:  tx_data_o = cdc_app_pkg::rev8(crc_out[31:24]);
         cdc_app_pkg::TX_CRC1:  tx_data_o = cdc_app_pkg::rev8(crc_out[23:16]);
         cdc_app_pkg::TX_CRC2:  tx_data_o = cdc_app_pkg::rev8(crc_out[15:8]);
         cdc_app_pkg::TX_CRC3:  tx_data_o = cdc_app_pkg::rev8(crc_out[7:0]);
         cdc_app_pkg::TX_RAM:   tx_data_o = ram_rdata_i;
         default:               tx_data_o = '0;
      endcase
   end

endmodule

/* design/app_pacer.sv */
`timescale 1ns/1ps
// byte count for data phases and the inter-byte gap timer
// a gap of WAIT cycles follows every data byte, WAIT of 0 gives none
module app_pacer (
   input  logic                           clk_i,
   input  logic                           rstn,
   app_ctrl_if.unit                       ctrl,
   input  logic [cdc_app_pkg::BYTE_W-1:0] rx_byte_i,
   output logic                           cnt_zero_o,
   output logic                           wait_done_o
);

   logic [cdc_app_pkg::CNT_W-1:0]  cnt_q;
   logic [cdc_app_pkg::WAIT_W-1:0] wait_q;
   logic [cdc_app_pkg::WAIT_W-1:0] wait_cnt_q;

   assign cnt_zero_o  = (cnt_q == '0);
   assign wait_done_o = (wait_cnt_q == '0);

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         cnt_q      <= '0;
         wait_q     <= '0;
         wait_cnt_q <= '0;
      end else begin
         if (ctrl.cnt_load)
            cnt_q[ctrl.lane*cdc_app_pkg::BYTE_W +: cdc_app_pkg::BYTE_W] <= rx_byte_i;
         else if (ctrl.cnt_dec)
            cnt_q <= cnt_q - 1'b1;

         if (ctrl.wait_load)
            wait_q <= rx_byte_i;

         // a running gap is not restarted
         if (!wait_done_o)
            wait_cnt_q <= wait_cnt_q - 1'b1;
         else if (ctrl.pace_start)
            wait_cnt_q <= wait_q;
      end
   end

   // the FSM ends a data phase on zero, so it never asks to go below it
   a_cnt_no_underflow: assert property (@(posedge clk_i) disable iff (!rstn)
      ctrl.cnt_dec |-> !cnt_zero_o);

endmodule

/* design/app_sequencer.sv */
`timescale 1ns/1ps
// command FSM, parameter bytes come least significant first
// unknown command codes drop back to loopback without a response
module app_sequencer (
   input  logic                           clk_i,
   input  logic                           rstn,
   app_ctrl_if.seq                        ctrl,
   input  logic [cdc_app_pkg::BYTE_W-1:0] rx_byte_i,
   input  logic                           rx_valid_i,
   input  logic                           tx_ready_i,
   input  logic                           cnt_zero_i,
   input  logic                           wait_done_i,
   output logic                           tx_valid_o
);

   cdc_app_pkg::state_e            state_q, state_d;
   logic [cdc_app_pkg::BYTE_W-1:0] cmd_q, cmd_d;
   logic                           ram_vld_q, ram_vld_d;
   logic                           run_q;
   logic                           tx_req;
   logic                           tx_ready;
   logic                           param_cmd;
   logic                           cnt_cmd;
   logic [3:0]                     cmd_ofs;
   logic [3:0]                     rd_ofs;

   assign tx_ready     = tx_ready_i & wait_done_i;
   assign tx_valid_o   = tx_req & wait_done_i;
   assign ctrl.rx_open = run_q & wait_done_i;

   assign cnt_cmd   = cmd_q inside {cdc_app_pkg::CMD_IN, cdc_app_pkg::CMD_OUT,
                                    cdc_app_pkg::CMD_RAM_READ};
   assign param_cmd = cnt_cmd | (cmd_q == cdc_app_pkg::CMD_ADDR)
                    | (cmd_q == cdc_app_pkg::CMD_LFSR_WRITE);
   assign cmd_ofs   = state_q - cdc_app_pkg::ST_CMD1;
   assign rd_ofs    = state_q - cdc_app_pkg::ST_READ0;

   always_comb begin
      state_d          = state_q;
      cmd_d            = cmd_q;
      ram_vld_d        = ram_vld_q;
      tx_req           = 1'b0;
      ctrl.tx_sel      = cdc_app_pkg::TX_LOOP;
      ctrl.lane        = cmd_ofs[1:0];
      ctrl.rx_take     = 1'b0;
      ctrl.crc_init    = 1'b0;
      ctrl.crc_rx_step = 1'b0;
      ctrl.crc_tx_step = 1'b0;
      ctrl.lfsr_step   = 1'b0;
      ctrl.lfsr_load   = 1'b0;
      ctrl.addr_load   = 1'b0;
      ctrl.addr_clr    = 1'b0;
      ctrl.ram_we      = 1'b0;
      ctrl.ram_rd      = 1'b0;
      ctrl.cnt_load    = 1'b0;
      ctrl.cnt_dec     = 1'b0;
      ctrl.wait_load   = 1'b0;
      ctrl.pace_start  = 1'b0;
      case (state_q)
         cdc_app_pkg::ST_RESET: begin
            if (rx_valid_i)
               state_d = cdc_app_pkg::ST_LOOPBACK;
         end
         cdc_app_pkg::ST_LOOPBACK: begin
            if (rx_valid_i && rx_byte_i == '0) begin
               ctrl.rx_take = 1'b1;
               state_d      = cdc_app_pkg::ST_CMD0;
            end else if (rx_valid_i) begin
               // echo and capture together
               tx_req       = 1'b1;
               ctrl.rx_take = tx_ready;
               ctrl.ram_we  = tx_ready;
            end
         end
         cdc_app_pkg::ST_CMD0: begin
            ctrl.rx_take = 1'b1;
            if (rx_valid_i) begin
               cmd_d   = rx_byte_i;
               state_d = cdc_app_pkg::ST_CMD1;
            end
         end
         cdc_app_pkg::ST_CMD1, cdc_app_pkg::ST_CMD2, cdc_app_pkg::ST_CMD3: begin
            // CRC restarts ahead of every data phase
            ctrl.crc_init = (state_q == cdc_app_pkg::ST_CMD3);
            if (param_cmd) begin
               ctrl.rx_take = 1'b1;
               if (rx_valid_i) begin
                  ctrl.cnt_load  = cnt_cmd;
                  ctrl.addr_load = (cmd_q == cdc_app_pkg::CMD_ADDR);
                  ctrl.lfsr_load = (cmd_q == cdc_app_pkg::CMD_LFSR_WRITE);
                  if (state_q != cdc_app_pkg::ST_CMD3)
                     state_d = cdc_app_pkg::state_e'(state_q + 4'd1);
                  else if (cmd_q == cdc_app_pkg::CMD_IN)
                     state_d = cdc_app_pkg::ST_IN;
                  else if (cmd_q == cdc_app_pkg::CMD_OUT)
                     state_d = cdc_app_pkg::ST_OUT;
                  else if (cmd_q == cdc_app_pkg::CMD_RAM_READ)
                     state_d = cdc_app_pkg::ST_READ_RAM;
                  else
                     state_d = cdc_app_pkg::ST_LOOPBACK;
               end
            end else if (state_q == cdc_app_pkg::ST_CMD1 && cmd_q == cdc_app_pkg::CMD_WAIT) begin
               ctrl.rx_take = 1'b1;
               if (rx_valid_i) begin
                  ctrl.wait_load = 1'b1;
                  state_d        = cdc_app_pkg::ST_LOOPBACK;
               end
            end else if (state_q == cdc_app_pkg::ST_CMD1
                         && cmd_q == cdc_app_pkg::CMD_LFSR_READ) begin
               state_d = cdc_app_pkg::ST_READ0;
            end else begin
               state_d = cdc_app_pkg::ST_LOOPBACK;
            end
         end
         cdc_app_pkg::ST_IN: begin
            tx_req      = 1'b1;
            ctrl.tx_sel = cdc_app_pkg::TX_LFSR0;
            if (tx_ready) begin
               ctrl.crc_tx_step = 1'b1;
               ctrl.lfsr_step   = 1'b1;
               ctrl.pace_start  = 1'b1;
               ctrl.cnt_dec     = ~cnt_zero_i;
               if (cnt_zero_i)
                  state_d = cdc_app_pkg::ST_READ0;
            end
         end
         cdc_app_pkg::ST_OUT: begin
            ctrl.rx_take = 1'b1;
            if (rx_valid_i) begin
               ctrl.crc_rx_step = 1'b1;
               ctrl.pace_start  = 1'b1;
               ctrl.cnt_dec     = ~cnt_zero_i;
               if (cnt_zero_i)
                  state_d = cdc_app_pkg::ST_READ0;
            end
         end
         cdc_app_pkg::ST_READ0, cdc_app_pkg::ST_READ1,
         cdc_app_pkg::ST_READ2, cdc_app_pkg::ST_READ3: begin
            tx_req = 1'b1;
            if (cmd_q == cdc_app_pkg::CMD_LFSR_READ)
               ctrl.tx_sel = cdc_app_pkg::tx_sel_e'(cdc_app_pkg::TX_LFSR0 + rd_ofs);
            else
               ctrl.tx_sel = cdc_app_pkg::tx_sel_e'(cdc_app_pkg::TX_CRC0 + rd_ofs);
            if (tx_ready && state_q == cdc_app_pkg::ST_READ3)
               state_d = cdc_app_pkg::ST_LOOPBACK;
            else if (tx_ready)
               state_d = cdc_app_pkg::state_e'(state_q + 4'd1);
         end
         cdc_app_pkg::ST_READ_RAM: begin
            tx_req      = ram_vld_q;
            ctrl.tx_sel = ram_vld_q ? cdc_app_pkg::TX_RAM : cdc_app_pkg::TX_ZERO;
            if (!ram_vld_q) begin
               ctrl.ram_rd = 1'b1;
               ram_vld_d   = 1'b1;
            end else if (tx_ready) begin
               ctrl.pace_start = 1'b1;
               if (cnt_zero_i) begin
                  ram_vld_d     = 1'b0;
                  ctrl.addr_clr = 1'b1;
                  state_d       = cdc_app_pkg::ST_LOOPBACK;
               end else begin
                  // fetch the next byte straight away, the flag stays set
                  ctrl.cnt_dec = 1'b1;
                  ctrl.ram_rd  = 1'b1;
               end
            end
         end
         default: state_d = cdc_app_pkg::ST_LOOPBACK;
      endcase
   end

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         state_q   <= cdc_app_pkg::ST_RESET;
         cmd_q     <= cdc_app_pkg::CMD_NO;
         ram_vld_q <= 1'b0;
         run_q     <= 1'b0;
      end else begin
         state_q   <= state_d;
         cmd_q     <= cmd_d;
         ram_vld_q <= ram_vld_d;
         run_q     <= 1'b1;
      end
   end

   // each RAM byte on the bus is freshly read or still waiting for its handshake
   a_ram_data_ready: assert property (@(posedge clk_i) disable iff (!rstn)
      ctrl.tx_sel == cdc_app_pkg::TX_RAM
      |-> $past(ctrl.ram_rd) || $past(ctrl.tx_sel == cdc_app_pkg::TX_RAM && !tx_ready));

endmodule

/* design/app_ctrl_if.sv */
`timescale 1ns/1ps
// strobes from the command FSM to the pacer, datapath and loopback RAM
// lane picks the parameter byte for every load strobe
interface app_ctrl_if;

   logic                  crc_init;
   logic                  crc_rx_step;
   logic                  crc_tx_step;
   logic                  lfsr_step;
   logic                  lfsr_load;
   logic [1:0]            lane;
   logic                  addr_load;
   logic                  addr_clr;
   logic                  ram_we;
   logic                  ram_rd;
   logic                  cnt_load;
   logic                  cnt_dec;
   logic                  wait_load;
   logic                  pace_start;
   logic                  rx_take;
   // receive side may accept a new byte
   logic                  rx_open;
   cdc_app_pkg::tx_sel_e  tx_sel;

   modport seq (
      output crc_init, crc_rx_step, crc_tx_step, lfsr_step, lfsr_load, lane,
             addr_load, addr_clr, ram_we, ram_rd, cnt_load, cnt_dec,
             wait_load, pace_start, rx_take, rx_open, tx_sel
   );

   modport unit (
      input  crc_init, crc_rx_step, crc_tx_step, lfsr_step, lfsr_load, lane,
             addr_load, addr_clr, ram_we, ram_rd, cnt_load, cnt_dec,
             wait_load, pace_start, rx_take, rx_open, tx_sel
   );

endinterface

/* design/cdc_app_pkg.sv */
// types, constants and CRC helpers shared by the CDC byte application
// crc32_byte takes data bits LSB first, so output bytes need rev8 of the complement
package cdc_app_pkg;

   localparam int BYTE_W = 8;
   localparam int CNT_W  = 24;
   localparam int WAIT_W = 8;

   localparam logic [31:0] CRC_POLY  = 32'h04C1_1DB7;
   localparam logic [31:0] CRC_INIT  = 32'hFFFF_FFFF;
   localparam logic [23:0] LFSR_TAPS = 24'hE1_0000;

   typedef enum logic [7:0] {
      CMD_NO         = 8'd0,
      CMD_IN         = 8'd1,
      CMD_OUT        = 8'd2,
      CMD_ADDR       = 8'd3,
      CMD_WAIT       = 8'd4,
      CMD_LFSR_WRITE = 8'd5,
      CMD_LFSR_READ  = 8'd6,
      CMD_RAM_READ   = 8'd8
   } cmd_e;

   typedef enum logic [3:0] {
      ST_RESET, ST_LOOPBACK,
      ST_CMD0, ST_CMD1, ST_CMD2, ST_CMD3,
      ST_IN, ST_OUT,
      ST_READ0, ST_READ1, ST_READ2, ST_READ3,
      ST_READ_RAM
   } state_e;

   // LFSR and CRC lanes stay consecutive, the FSM steps through them by offset
   typedef enum logic [3:0] {
      TX_LOOP, TX_LFSR0, TX_LFSR1, TX_LFSR2, TX_ZERO,
      TX_CRC0, TX_CRC1, TX_CRC2, TX_CRC3, TX_RAM
   } tx_sel_e;

   function automatic logic [31:0] crc32_byte(input logic [7:0] data,
                                              input logic [31:0] crc);
      logic [31:0] c;
      c = crc;
      for (int i = 0; i < 8; i++) begin
         if (data[i] ^ c[31])
            c = {c[30:0], 1'b0} ^ CRC_POLY;
         else
            c = {c[30:0], 1'b0};
      end
      return c;
   endfunction

   function automatic logic [7:0] rev8(input logic [7:0] data);
      logic [7:0] r;
      for (int i = 0; i < 8; i++) begin
         r[i] = data[7-i];
      end
      return r;
   endfunction

endpackage
